//--- flist.f
source/cachePkg.sv
source/cacheWay.sv
source/waySelect.sv
source/cacheController.sv
source/dataCacheTop.sv
tests/cacheChecker.sv
tests/cacheTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
mkdir -p build &&
  verilator --binary --timing --assert --top-module cacheTb -Mdir build -o simv -f flist.f ||
  { echo "Verilator build failed"; exit 1; }
./build/simv > sim.log 2>&1
cat sim.log
grep -qx "All checks passed" sim.log && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

//--- tests/cacheTb.sv
`timescale 1ns/1ps

module cacheTb;

  localparam int directedRequests = 8;
  localparam int randomRequests = 300;
  localparam int numRequests = directedRequests + randomRequests;
  localparam int maxCycles = numRequests * 60 + 10;

  logic clk = 1'b0;
  logic reset;
  logic cpuReqValid;
  logic cpuWrite;
  logic [31:0] cpuAddr;
  logic [31:0] cpuWdata;
  logic [3:0] cpuByteMask;
  logic cpuReqReady;
  logic cpuRspValid;
  logic [31:0] cpuRdata;
  logic memReqValid;
  cachePkg::memOp memOpcode;
  logic [31:0] memAddr;
  logic [31:0] memWdata;
  logic memReqReady;
  logic memRspValid;
  logic [31:0] memRdata;

  // Memory model state
  logic [31:0] mem [4096];
  logic [31:0] stimSeed = 32'h919;
  logic [31:0] memSeed = 32'h919;
  logic [31:0] memDraw;
  logic [31:0] rspWord;
  int rspDelay;
  int valueErrors;
  int protocolErrors;
  int responses;

  always #4 clk = ~clk;

  dataCacheTop dataCacheTop_i (
    .clk, .reset,
    .cpuReqValid, .cpuWrite, .cpuAddr, .cpuWdata, .cpuByteMask,
    .cpuReqReady, .cpuRspValid, .cpuRdata,
    .memReqValid, .memOpcode, .memAddr, .memWdata,
    .memReqReady, .memRspValid, .memRdata
  );

  cacheChecker checker_i (
    .clk, .reset,
    .cpuReqValid, .cpuReqReady, .cpuWrite, .cpuAddr, .cpuWdata, .cpuByteMask,
    .cpuRspValid, .cpuRdata,
    .memReqValid, .memReqReady, .memOpcode, .memAddr, .memWdata,
    .valueErrors, .protocolErrors, .responses
  );

  function automatic logic [31:0] lcgNext(inout logic [31:0] seed);
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] fillPattern(input logic [11:0] idx);
    return {idx, 4'ha, ~idx, 4'h5};
  endfunction

  // Pool of 4 tags and 4 sets keeps conflicts frequent
  function automatic logic [31:0] makeAddr(input logic [3:0] tag, input logic [5:0] setIdx,
                                           input logic [1:0] off);
    return {18'd0, tag, setIdx, off, 2'b00};
  endfunction

  task automatic runRequest(input logic write, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] mask);
    cpuReqValid <= 1'b1;
    cpuWrite <= write;
    cpuAddr <= addr;
    cpuWdata <= data;
    cpuByteMask <= mask;
    do @(posedge clk); while (!cpuReqReady);
    cpuReqValid <= 1'b0;
    do @(posedge clk); while (!cpuRspValid);
  endtask

  // Word memory with random stalls and 0 to 3 cycles of read latency
  initial begin
    memReqReady = 1'b0;
    memRspValid = 1'b0;
    memRdata = '0;
    rspDelay = -1;
    forever begin
      @(posedge clk);
      memDraw = lcgNext(memSeed);
      memReqReady <= memDraw[31:30] != 2'b00;
      memRspValid <= 1'b0;
      if (reset) begin
        for (int i = 0; i < 4096; i++) begin
          mem[12'(i)] = fillPattern(12'(i));
        end
        rspDelay = -1;
      end else begin
        if (rspDelay == 0) begin
          memRspValid <= 1'b1;
          memRdata <= rspWord;
        end
        if (rspDelay >= 0) begin
          rspDelay--;
        end
        if (memReqValid && memReqReady) begin
          if (memOpcode == cachePkg::memOpWrite) begin
            mem[memAddr[13:2]] = memWdata;
          end else begin
            rspWord = mem[memAddr[13:2]];
            rspDelay = int'(memDraw[29:28]);
          end
        end
      end
    end
  end

  initial begin
    logic [31:0] r;
    cpuReqValid = 1'b0;
    cpuWrite = 1'b0;
    cpuAddr = '0;
    cpuWdata = '0;
    cpuByteMask = '0;
    reset = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // Cold miss, then a hit in the filled block
    runRequest(1'b0, makeAddr(4'd0, 6'd1, 2'd2), '0, 4'h0);
    runRequest(1'b0, makeAddr(4'd0, 6'd1, 2'd1), '0, 4'h0);
    // Masked store hit and its readback
    r = lcgNext(stimSeed);
    runRequest(1'b1, makeAddr(4'd0, 6'd1, 2'd1), lcgNext(stimSeed), r[31:28]);
    runRequest(1'b0, makeAddr(4'd0, 6'd1, 2'd1), '0, 4'h0);
    // Second dirty line in set 1, then a third tag evicts one
    runRequest(1'b1, makeAddr(4'd1, 6'd1, 2'd3), lcgNext(stimSeed), 4'hf);
    runRequest(1'b0, makeAddr(4'd2, 6'd1, 2'd0), '0, 4'h0);
    // Store miss onto a dirty victim, then the merged word
    runRequest(1'b1, makeAddr(4'd3, 6'd1, 2'd2), lcgNext(stimSeed), 4'b0101);
    runRequest(1'b0, makeAddr(4'd3, 6'd1, 2'd2), '0, 4'h0);

    for (int n = 0; n < randomRequests; n++) begin
      r = lcgNext(stimSeed);
      runRequest(r[31], makeAddr({2'b00, r[29:28]}, {4'd0, r[27:26]}, r[25:24]),
                 lcgNext(stimSeed), r[23:20]);
    end

    @(posedge clk);
    $display("Closing: %0d value errors, %0d protocol errors, %0d of %0d responses",
             valueErrors, protocolErrors, responses, numRequests);
    if (responses != numRequests) begin
      $display("Response count does not match the number of requests");
    end
    if (valueErrors == 0 && protocolErrors == 0 && responses == numRequests) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    repeat (maxCycles) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", maxCycles);
    $display("Checks failed");
    $finish;
  end

endmodule

//--- tests/cacheChecker.sv
`timescale 1ns/1ps

module cacheChecker (
  input  logic           clk,
  input  logic           reset,
  input  logic           cpuReqValid,
  input  logic           cpuReqReady,
  input  logic           cpuWrite,
  input  logic [31:0]    cpuAddr,
  input  logic [31:0]    cpuWdata,
  input  logic [3:0]     cpuByteMask,
  input  logic           cpuRspValid,
  input  logic [31:0]    cpuRdata,
  input  logic           memReqValid,
  input  logic           memReqReady,
  input  cachePkg::memOp memOpcode,
  input  logic [31:0]    memAddr,
  input  logic [31:0]    memWdata,
  output int             valueErrors,
  output int             protocolErrors,
  output int             responses
);

  // Byte image of what the processor should see
  logic [7:0] image [16384];
  logic [cachePkg::tagBits-1:0] modelTag [cachePkg::numWays][cachePkg::numSets];
  logic modelValid [cachePkg::numWays][cachePkg::numSets];
  logic modelDirty [cachePkg::numWays][cachePkg::numSets];
  logic modelLru [cachePkg::numSets];

  // Memory requests still owed by the current miss
  cachePkg::memOp expOp [$];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];

  logic pending;
  logic expHit;
  logic [31:0] expRdata;
  int cycle;
  int acceptCycle;

  function automatic logic [31:0] initialWord(input logic [11:0] idx);
    return {idx, 4'ha, ~idx, 4'h5};
  endfunction

  function automatic logic [31:0] wordAt(input logic [31:0] addr);
    return {image[{addr[13:2], 2'd3}], image[{addr[13:2], 2'd2}],
            image[{addr[13:2], 2'd1}], image[{addr[13:2], 2'd0}]};
  endfunction

  function automatic logic [31:0] blockAddr(input logic [cachePkg::tagBits-1:0] tag,
                                            input logic [cachePkg::setBits-1:0] setIdx,
                                            input int k);
    return {tag, setIdx, 2'(k), 2'b00};
  endfunction

  function automatic void expectMem(input cachePkg::memOp op, input logic [31:0] addr,
                                    input logic [31:0] data);
    expOp.push_back(op);
    expAddr.push_back(addr);
    expData.push_back(data);
  endfunction

  // Expected load or merged store word, plus the memory traffic of a miss
  function automatic logic [31:0] predictAccess(input logic write, input logic [31:0] addr,
                                                input logic [31:0] wdata,
                                                input logic [3:0] mask,
                                                output logic isHit);
    logic [cachePkg::tagBits-1:0] tag;
    logic [cachePkg::setBits-1:0] setIdx;
    logic way;
    tag = addr[cachePkg::tagLsb +: cachePkg::tagBits];
    setIdx = addr[cachePkg::setLsb +: cachePkg::setBits];
    isHit = 1'b0;
    way = 1'b0;
    for (int w = 0; w < cachePkg::numWays; w++) begin
      if (modelValid[w[0]][setIdx] && modelTag[w[0]][setIdx] == tag) begin
        isHit = 1'b1;
        way = w[0];
      end
    end
    if (!isHit) begin
      if (!modelValid[0][setIdx]) begin
        way = 1'b0;
      end else if (!modelValid[1][setIdx]) begin
        way = 1'b1;
      end else begin
        way = ~modelLru[setIdx];
      end
      // Dirty victim holds exactly the image bytes of its block
      if (modelValid[way][setIdx] && modelDirty[way][setIdx]) begin
        for (int k = 0; k < cachePkg::wordsPerBlock; k++) begin
          expectMem(cachePkg::memOpWrite, blockAddr(modelTag[way][setIdx], setIdx, k),
                    wordAt(blockAddr(modelTag[way][setIdx], setIdx, k)));
        end
      end
      for (int k = 0; k < cachePkg::wordsPerBlock; k++) begin
        expectMem(cachePkg::memOpRead, blockAddr(tag, setIdx, k), '0);
      end
      modelTag[way][setIdx] = tag;
      modelValid[way][setIdx] = 1'b1;
      modelDirty[way][setIdx] = 1'b0;
    end
    if (write) begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          image[{addr[13:2], 2'(b)}] = wdata[8*b +: 8];
        end
      end
      modelDirty[way][setIdx] = 1'b1;
    end
    modelLru[setIdx] = way;
    return wordAt(addr);
  endfunction

  always @(posedge clk) begin : watch
    logic [31:0] fill;
    if (reset) begin
      for (int i = 0; i < 4096; i++) begin
        fill = initialWord(12'(i));
        for (int b = 0; b < 4; b++) begin
          image[14'(4*i + b)] = fill[8*b +: 8];
        end
      end
      modelValid = '{default: '{default: 1'b0}};
      modelDirty = '{default: '{default: 1'b0}};
      modelLru = '{default: 1'b0};
      expOp.delete();
      expAddr.delete();
      expData.delete();
      pending = 1'b0;
      cycle = 0;
      valueErrors = 0;
      protocolErrors = 0;
      responses = 0;
    end else begin
      cycle++;
      // Ready only while no request is outstanding
      if (cpuReqReady != !pending) begin
        $display("** Error: cpuReqReady %h, expected %h", cpuReqReady, !pending);
        valueErrors++;
      end
      if (memReqValid && memReqReady) begin
        if (expOp.size() == 0) begin
          $display("Unexpected memory request to address %h", memAddr);
          protocolErrors++;
        end else begin
          if (memOpcode != expOp[0]) begin
            $display("** Error: memOpcode %h, expected %h", memOpcode, expOp[0]);
            valueErrors++;
          end
          if (memAddr != expAddr[0]) begin
            $display("** Error: memAddr %h, expected %h", memAddr, expAddr[0]);
            valueErrors++;
          end
          if (expOp[0] == cachePkg::memOpWrite && memWdata != expData[0]) begin
            $display("** Error: memWdata %h, expected %h", memWdata, expData[0]);
            valueErrors++;
          end
          void'(expOp.pop_front());
          void'(expAddr.pop_front());
          void'(expData.pop_front());
        end
      end
      if (cpuRspValid) begin
        responses++;
        if (!pending) begin
          $display("Response arrived with no request outstanding");
          protocolErrors++;
        end else begin
          if (cpuRdata != expRdata) begin
            $display("** Error: cpuRdata %h, expected %h", cpuRdata, expRdata);
            valueErrors++;
          end
          if (expHit && cycle != acceptCycle + 1) begin
            $display("Hit answered %0d cycles after acceptance", cycle - acceptCycle);
            protocolErrors++;
          end
          if (expOp.size() != 0) begin
            $display("Response came with %0d memory requests missing", expOp.size());
            protocolErrors++;
          end
        end
        pending = 1'b0;
      end
      if (cpuReqValid && cpuReqReady) begin
        expRdata = predictAccess(cpuWrite, cpuAddr, cpuWdata, cpuByteMask, expHit);
        pending = 1'b1;
        acceptCycle = cycle;
      end
    end
  end

endmodule

//--- source/dataCacheTop.sv
`timescale 1ns/1ps

module dataCacheTop (
  input  logic           clk,
  input  logic           reset,
  input  logic           cpuReqValid,
  input  logic           cpuWrite,
  input  logic [31:0]    cpuAddr,
  input  logic [31:0]    cpuWdata,
  input  logic [3:0]     cpuByteMask,
  output logic           cpuReqReady,
  output logic           cpuRspValid,
  output logic [31:0]    cpuRdata,
  output logic           memReqValid,
  output cachePkg::memOp memOpcode,
  output logic [31:0]    memAddr,
  output logic [31:0]    memWdata,
  input  logic           memReqReady,
  input  logic           memRspValid,
  input  logic [31:0]    memRdata
);

  logic [cachePkg::setBits-1:0] wayIndex;
  logic [cachePkg::offsetBits-1:0] wayOffset;
  logic [cachePkg::numWays-1:0] wayWe;
  logic wayFill;
  logic [31:0] wayWdata;
  logic [3:0] wayByteMask;
  logic [cachePkg::tagBits-1:0] wayNewTag;
  logic waySetDirty;

  // Per-way lookup outputs
  logic [cachePkg::numWays-1:0][cachePkg::tagBits-1:0] wayTag;
  logic [cachePkg::numWays-1:0] wayValid;
  logic [cachePkg::numWays-1:0] wayDirty;
  logic [cachePkg::numWays-1:0][31:0] wayRdata;

  logic hit;
  logic hitWay;
  logic victimWay;
  logic victimDirty;
  logic [cachePkg::tagBits-1:0] victimTag;
  logic [31:0] selRdata;
  logic lruUpdate;
  logic usedWay;

  cacheController controller_i (
    .clk, .reset,
    .cpuReqValid, .cpuWrite, .cpuAddr, .cpuWdata, .cpuByteMask,
    .cpuReqReady, .cpuRspValid, .cpuRdata,
    .memReqValid, .memOpcode, .memAddr, .memWdata,
    .memReqReady, .memRspValid, .memRdata,
    .hit, .hitWay, .victimWay, .victimDirty, .victimTag, .selRdata,
    .wayIndex, .wayOffset, .wayWe, .wayFill, .wayWdata, .wayByteMask,
    .wayNewTag, .waySetDirty, .lruUpdate, .usedWay
  );

  for (genvar g = 0; g < cachePkg::numWays; g++) begin : wayGen
    cacheWay way_i (
      .clk, .reset,
      .index(wayIndex),
      .offset(wayOffset),
      .we(wayWe[g]),
      .fill(wayFill),
      .wdata(wayWdata),
      .byteMask(wayByteMask),
      .newTag(wayNewTag),
      .setDirty(waySetDirty),
      .tag(wayTag[g]),
      .valid(wayValid[g]),
      .dirty(wayDirty[g]),
      .rdata(wayRdata[g])
    );
  end

  // Lookup tag follows the controller's current request
  waySelect waySelect_i (
    .clk, .reset,
    .reqTag(wayNewTag),
    .index(wayIndex),
    .wayTag, .wayValid, .wayDirty, .wayRdata,
    .lruUpdate, .usedWay,
    .hit, .hitWay, .victimWay, .victimDirty, .victimTag,
    .rdata(selRdata)
  );

endmodule

//--- source/cacheController.sv
`timescale 1ns/1ps

module cacheController (
  input  logic                            clk,
  input  logic                            reset,
  // Processor side
  input  logic                            cpuReqValid,
  input  logic                            cpuWrite,
  input  logic [31:0]                     cpuAddr,
  input  logic [31:0]                     cpuWdata,
  input  logic [3:0]                      cpuByteMask,
  output logic                            cpuReqReady,
  output logic                            cpuRspValid,
  output logic [31:0]                     cpuRdata,
  // Memory side
  output logic                            memReqValid,
  output cachePkg::memOp                  memOpcode,
  output logic [31:0]                     memAddr,
  output logic [31:0]                     memWdata,
  input  logic                            memReqReady,
  input  logic                            memRspValid,
  input  logic [31:0]                     memRdata,
  // Lookup results
  input  logic                            hit,
  input  logic                            hitWay,
  input  logic                            victimWay,
  input  logic                            victimDirty,
  input  logic [cachePkg::tagBits-1:0]    victimTag,
  input  logic [31:0]                     selRdata,
  // Way control
  output logic [cachePkg::setBits-1:0]    wayIndex,
  output logic [cachePkg::offsetBits-1:0] wayOffset,
  output logic [cachePkg::numWays-1:0]    wayWe,
  output logic                            wayFill,
  output logic [31:0]                     wayWdata,
  output logic [3:0]                      wayByteMask,
  output logic [cachePkg::tagBits-1:0]    wayNewTag,
  output logic                            waySetDirty,
  output logic                            lruUpdate,
  output logic                            usedWay
);

  cachePkg::cacheState state, nextState;
  logic [cachePkg::offsetBits-1:0] wordCount;
  logic rspPending;
  logic readPending;
  logic lookupLive;
  logic accept;
  logic wordAdvance;
  logic [31:0] fillWord;

  // Request captured at acceptance
  logic [cachePkg::tagBits-1:0] reqTag;
  logic [cachePkg::setBits-1:0] reqIndex;
  logic [cachePkg::offsetBits-1:0] reqOffset;
  logic reqWrite;
  logic [31:0] reqWdata;
  logic [3:0] reqMask;
  logic missWay;
  logic [cachePkg::tagBits-1:0] missTag;

  // Ways look at the live address only while a new request can be taken
  assign lookupLive = (state == cachePkg::ready) && !rspPending;
  assign cpuReqReady = lookupLive;
  assign accept = cpuReqValid && cpuReqReady;

  assign wayIndex = lookupLive ? cpuAddr[cachePkg::setLsb +: cachePkg::setBits] : reqIndex;
  assign wayNewTag = lookupLive ? cpuAddr[cachePkg::tagLsb +: cachePkg::tagBits] : reqTag;

  always_comb begin
    if (lookupLive) begin
      wayOffset = cpuAddr[cachePkg::offsetLsb +: cachePkg::offsetBits];
    end else if (state == cachePkg::writeBack || state == cachePkg::memRead) begin
      wayOffset = wordCount;
    end else begin
      wayOffset = reqOffset;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqTag <= cpuAddr[cachePkg::tagLsb +: cachePkg::tagBits];
      reqIndex <= cpuAddr[cachePkg::setLsb +: cachePkg::setBits];
      reqOffset <= cpuAddr[cachePkg::offsetLsb +: cachePkg::offsetBits];
      reqWrite <= cpuWrite;
      reqWdata <= cpuWdata;
      reqMask <= cpuByteMask;
      missWay <= victimWay;
      missTag <= victimTag;
    end
  end

  // One step per accepted write or returned read
  assign wordAdvance = (state == cachePkg::writeBack && memReqReady) ||
                       (state == cachePkg::memRead && memRspValid);

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state <= cachePkg::ready;
      wordCount <= '0;
      rspPending <= 1'b0;
      readPending <= 1'b0;
    end else begin
      state <= nextState;
      rspPending <= accept && hit;
      if (wordAdvance) begin
        wordCount <= wordCount + 1'b1;
      end
      if (state == cachePkg::memRead && memReqValid && memReqReady) begin
        readPending <= 1'b1;
      end else if (memRspValid) begin
        readPending <= 1'b0;
      end
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      cachePkg::ready: begin
        if (accept && !hit) begin
          nextState = victimDirty ? cachePkg::writeBack : cachePkg::memRead;
        end
      end
      cachePkg::writeBack: begin
        if (memReqReady && wordCount == cachePkg::lastWord) begin
          nextState = cachePkg::memRead;
        end
      end
      cachePkg::memRead: begin
        if (memRspValid && wordCount == cachePkg::lastWord) begin
          nextState = cachePkg::refillDone;
        end
      end
      default: nextState = cachePkg::ready;
    endcase
  end

  // Memory port, one request in flight at most
  assign memReqValid = (state == cachePkg::writeBack) ||
                       (state == cachePkg::memRead && !readPending);
  assign memOpcode = (state == cachePkg::writeBack) ? cachePkg::memOpWrite
                                                    : cachePkg::memOpRead;
  assign memAddr = {(state == cachePkg::writeBack) ? missTag : reqTag,
                    reqIndex, wordCount, 2'b00};
  assign memWdata = selRdata;

  // Store data overrides the fetched word at the request offset
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      if (reqWrite && wordCount == reqOffset && reqMask[b]) begin
        fillWord[8*b +: 8] = reqWdata[8*b +: 8];
      end else begin
        fillWord[8*b +: 8] = memRdata[8*b +: 8];
      end
    end
  end

  always_comb begin
    wayWe = '0;
    wayFill = 1'b0;
    wayWdata = cpuWdata;
    wayByteMask = cpuByteMask;
    waySetDirty = 1'b0;
    if (state == cachePkg::memRead && memRspValid) begin
      wayWe[missWay] = 1'b1;
      wayFill = 1'b1;
      wayWdata = fillWord;
      wayByteMask = 4'hf;
      waySetDirty = reqWrite;
    end else if (accept && hit && cpuWrite) begin
      wayWe[hitWay] = 1'b1;
      waySetDirty = 1'b1;
    end
  end

  assign lruUpdate = (accept && hit) || (state == cachePkg::refillDone);
  assign usedWay = (state == cachePkg::refillDone) ? missWay : hitWay;

  // Both hit and refill answers read back through the ways
  assign cpuRspValid = rspPending || (state == cachePkg::refillDone);
  assign cpuRdata = selRdata;

  memHoldsUnderStall: assert property (@(posedge clk) disable iff (reset)
    memReqValid && !memReqReady |=> memReqValid && $stable(memAddr) &&
                                    $stable(memOpcode) && $stable(memWdata));

  // Counter wraps back to zero by the end of each burst
  counterAtRest: assert property (@(posedge clk) disable iff (reset)
    (state == cachePkg::ready || state == cachePkg::refillDone) |-> wordCount == '0);

endmodule

//--- source/waySelect.sv
`timescale 1ns/1ps

module waySelect (
  input  logic                                               clk,
  input  logic                                               reset,
  input  logic [cachePkg::tagBits-1:0]                       reqTag,
  input  logic [cachePkg::setBits-1:0]                       index,
  input  logic [cachePkg::numWays-1:0][cachePkg::tagBits-1:0] wayTag,
  input  logic [cachePkg::numWays-1:0]                       wayValid,
  input  logic [cachePkg::numWays-1:0]                       wayDirty,
  input  logic [cachePkg::numWays-1:0][31:0]                 wayRdata,
  input  logic                                               lruUpdate,
  input  logic                                               usedWay,
  output logic                                               hit,
  output logic                                               hitWay,
  output logic                                               victimWay,
  output logic                                               victimDirty,
  output logic [cachePkg::tagBits-1:0]                       victimTag,
  output logic [31:0]                                        rdata
);

  // Most recently used way of each set
  logic [cachePkg::numSets-1:0] lruBits;
  logic [cachePkg::numWays-1:0] wayHit;

  always_comb begin
    for (int w = 0; w < cachePkg::numWays; w++) begin
      wayHit[w] = wayValid[w] && (wayTag[w] == reqTag);
    end
  end

  assign hit = |wayHit;
  assign hitWay = wayHit[1];

  // Empty way first, otherwise the one not used last
  always_comb begin
    if (!wayValid[0]) begin
      victimWay = 1'b0;
    end else if (!wayValid[1]) begin
      victimWay = 1'b1;
    end else begin
      victimWay = ~lruBits[index];
    end
  end

  assign victimDirty = wayDirty[victimWay];
  assign victimTag = wayTag[victimWay];

  // Victim word goes out on a miss so write-back can read it
  assign rdata = hit ? wayRdata[hitWay] : wayRdata[victimWay];

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (lruUpdate) begin
      lruBits[index] <= usedWay;
    end
  end

  // A refill never duplicates a resident tag
  singleHit: assert property (@(posedge clk) disable iff (reset)
    !(wayHit[0] && wayHit[1]));

endmodule

//--- source/cacheWay.sv
`timescale 1ns/1ps

module cacheWay (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [cachePkg::setBits-1:0]    index,
  input  logic [cachePkg::offsetBits-1:0] offset,
  input  logic                            we,
  input  logic                            fill,
  input  logic [31:0]                     wdata,
  input  logic [3:0]                      byteMask,
  input  logic [cachePkg::tagBits-1:0]    newTag,
  input  logic                            setDirty,
  output logic [cachePkg::tagBits-1:0]    tag,
  output logic                            valid,
  output logic                            dirty,
  output logic [31:0]                     rdata
);

  logic [cachePkg::tagBits-1:0] tagMem [cachePkg::numSets];
  logic [31:0] dataMem [cachePkg::numSets][cachePkg::wordsPerBlock];
  logic [cachePkg::numSets-1:0] validBits;
  logic [cachePkg::numSets-1:0] dirtyBits;
  logic [31:0] mergedWord;

  // Lookup is purely combinational
  assign tag = tagMem[index];
  assign valid = validBits[index];
  assign dirty = dirtyBits[index];
  assign rdata = dataMem[index][offset];

  // Refill takes the whole word, a store keeps the unmasked bytes
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      mergedWord[8*b +: 8] = (fill || byteMask[b]) ? wdata[8*b +: 8] : rdata[8*b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      dataMem[index][offset] <= mergedWord;
      if (fill) begin
        tagMem[index] <= newTag;
      end
    end
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else if (we) begin
      if (fill) begin
        validBits[index] <= 1'b1;
        dirtyBits[index] <= setDirty;
      end else if (setDirty) begin
        dirtyBits[index] <= 1'b1;
      end
    end
  end

  // Stores only ever land on a resident line
  storeToValidLine: assert property (@(posedge clk) disable iff (reset)
    we && !fill |-> validBits[index]);

endmodule

//--- source/cachePkg.sv
package cachePkg;

  // Cache geometry
  localparam int numSets = 64;
  localparam int numWays = 2;
  localparam int wordsPerBlock = 4;

  // Byte address fields, tag | set | word offset | byte
  localparam int byteBits = 2;
  localparam int setBits = $clog2(numSets);
  localparam int offsetBits = $clog2(wordsPerBlock);
  localparam int tagBits = 32 - setBits - offsetBits - byteBits;

  // Field positions inside a byte address
  localparam int offsetLsb = byteBits;
  localparam int setLsb = offsetLsb + offsetBits;
  localparam int tagLsb = setLsb + setBits;

  // Counter value of the final word of a block
  localparam logic [offsetBits-1:0] lastWord = offsetBits'(wordsPerBlock - 1);

  // Controller states
  typedef enum logic [1:0] {
    ready,
    writeBack,
    memRead,
    refillDone
  } cacheState;

  // Memory port operation
  typedef enum logic {
    memOpRead,
    memOpWrite
  } memOp;

endpackage
